//--- rtl/l1_pkg.sv
// Shared types and default sizes for the L1 data cache.
// Imported by every cache module and by the testbench.

package l1_pkg;

    // ====================
    // coherence and control states
    // ====================

    // INVALID must stay zero so that reset clears lines
    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        SHARED    = 2'b01,
        EXCLUSIVE = 2'b10,
        MODIFIED  = 2'b11
    } mesi_e;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        DONE       = 3'd1,
        ARB        = 3'd2,
        WRITEBACK  = 3'd3,
        FILL       = 3'd4,
        INVALIDATE = 3'd5
    } ctrl_state_e;

    // ====================
    // default geometry
    // ====================

    localparam int DEF_NUM_WAYS = 4;
    localparam int DEF_NUM_SETS = 16;
    localparam int DEF_ADDR_WID = 32;
    localparam int DEF_DATA_WID = 32;

    // one word per line
    localparam int OFFSET_WID   = 2;

endpackage

//--- rtl/l1_way_array.sv
// One way of the L1 data cache: tag, MESI state and data per set.
// Looks up the processor and snoop addresses in parallel.

`timescale 1ns/1ps

module l1_way_array
    import l1_pkg::*;
#(
    parameter int NUM_SETS = DEF_NUM_SETS,
    parameter int ADDR_WID = DEF_ADDR_WID,
    parameter int DATA_WID = DEF_DATA_WID
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [ADDR_WID-1:0]                  proc_addr,
    input  logic [ADDR_WID-1:0]                  snoop_addr,
    input  logic                                 wr_en,
    input  logic [$clog2(NUM_SETS)-1:0]          wr_index,
    input  logic [ADDR_WID-$clog2(NUM_SETS)-OFFSET_WID-1:0] wr_tag,
    input  logic [DATA_WID-1:0]                  wr_data,
    input  mesi_e                                wr_state,
    input  logic                                 snoop_inv_en,
    output logic                                 proc_hit,
    output mesi_e                                proc_state,
    output logic [ADDR_WID-$clog2(NUM_SETS)-OFFSET_WID-1:0] proc_tag,
    output logic [DATA_WID-1:0]                  proc_data,
    output logic                                 snoop_hit
);

    localparam int INDEX_WID = $clog2(NUM_SETS);
    localparam int TAG_WID   = ADDR_WID - INDEX_WID - OFFSET_WID;

    logic [TAG_WID-1:0]  tag_mem   [NUM_SETS];
    logic [DATA_WID-1:0] data_mem  [NUM_SETS];
    mesi_e               state_mem [NUM_SETS];

    logic [INDEX_WID-1:0] proc_index;
    logic [INDEX_WID-1:0] snoop_index;

    assign proc_index  = proc_addr[OFFSET_WID +: INDEX_WID];
    assign snoop_index = snoop_addr[OFFSET_WID +: INDEX_WID];

    // lookups, INVALID never hits
    assign proc_state = state_mem[proc_index];
    assign proc_tag   = tag_mem[proc_index];
    assign proc_data  = data_mem[proc_index];
    assign proc_hit   = (proc_state != INVALID) &&
                        (proc_tag == proc_addr[ADDR_WID-1 -: TAG_WID]);
    assign snoop_hit  = (state_mem[snoop_index] != INVALID) &&
                        (tag_mem[snoop_index] == snoop_addr[ADDR_WID-1 -: TAG_WID]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                state_mem[s] <= INVALID;
            end
        end else if (snoop_inv_en && snoop_hit) begin
            state_mem[snoop_index] <= INVALID;
        end else if (wr_en) begin
            state_mem[wr_index] <= wr_state;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= wr_data;
        end
    end

    // controller serializes snoops against its own array writes
    a_no_wr_snoop_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && snoop_inv_en && (wr_index == snoop_index)))
        else $error("array write and snoop invalidate hit the same set");

endmodule

//--- rtl/l1_way_select.sv
// Reduces the per-way lookups to one hit and one victim.
// Holds the per-set round-robin pointers used when no way is free.

`timescale 1ns/1ps

module l1_way_select
    import l1_pkg::*;
#(
    parameter int NUM_WAYS = DEF_NUM_WAYS,
    parameter int NUM_SETS = DEF_NUM_SETS,
    parameter int ADDR_WID = DEF_ADDR_WID,
    parameter int DATA_WID = DEF_DATA_WID
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [ADDR_WID-1:0] proc_addr,
    input  logic [NUM_WAYS-1:0] way_hit,
    input  mesi_e               way_state [NUM_WAYS],
    input  logic [ADDR_WID-$clog2(NUM_SETS)-OFFSET_WID-1:0] way_tag [NUM_WAYS],
    input  logic [DATA_WID-1:0] way_data [NUM_WAYS],
    input  logic [NUM_WAYS-1:0] way_snoop_hit,
    input  logic                victim_advance,
    output logic                hit,
    output logic [NUM_WAYS-1:0] hit_way,
    output mesi_e               hit_state,
    output logic [DATA_WID-1:0] hit_data,
    output logic [NUM_WAYS-1:0] victim_way,
    output mesi_e               victim_state,
    output logic [ADDR_WID-$clog2(NUM_SETS)-OFFSET_WID-1:0] victim_tag,
    output logic [DATA_WID-1:0] victim_data,
    output logic                snoop_hit_any
);

    localparam int INDEX_WID = $clog2(NUM_SETS);
    localparam int WAY_WID   = $clog2(NUM_WAYS);

    logic [WAY_WID-1:0]   rr_ptr [NUM_SETS];
    logic [INDEX_WID-1:0] proc_index;
    logic [WAY_WID-1:0]   hit_idx;
    logic [WAY_WID-1:0]   inv_idx;
    logic [WAY_WID-1:0]   victim_idx;
    logic                 any_invalid;

    assign proc_index = proc_addr[OFFSET_WID +: INDEX_WID];

    // walk down so the lowest matching way wins
    always_comb begin
        hit_idx     = '0;
        inv_idx     = '0;
        any_invalid = 1'b0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (way_hit[i]) begin
                hit_idx = WAY_WID'(i);
            end
            if (way_state[i] == INVALID) begin
                inv_idx     = WAY_WID'(i);
                any_invalid = 1'b1;
            end
        end
    end

    assign hit           = |way_hit;
    assign hit_way       = way_hit;
    assign hit_state     = way_state[hit_idx];
    assign hit_data      = way_data[hit_idx];
    assign snoop_hit_any = |way_snoop_hit;

    assign victim_idx   = any_invalid ? inv_idx : rr_ptr[proc_index];
    assign victim_way   = NUM_WAYS'(1) << victim_idx;
    assign victim_state = way_state[victim_idx];
    assign victim_tag   = way_tag[victim_idx];
    assign victim_data  = way_data[victim_idx];

    // pointer only moves when a valid line was replaced
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (victim_advance && !any_invalid) begin
            if (rr_ptr[proc_index] == WAY_WID'(NUM_WAYS - 1)) begin
                rr_ptr[proc_index] <= '0;
            end else begin
                rr_ptr[proc_index] <= rr_ptr[proc_index] + 1'b1;
            end
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_hit))
        else $error("address present in more than one way");

endmodule

//--- rtl/l1_access_ctrl.sv
// Access controller of the L1 data cache.
// Serves CPU hits and snoop invalidations from IDLE, and runs the
// level-2 writeback, fill and invalidate transactions for the rest.

`timescale 1ns/1ps

module l1_access_ctrl
    import l1_pkg::*;
#(
    parameter int NUM_WAYS = DEF_NUM_WAYS,
    parameter int NUM_SETS = DEF_NUM_SETS,
    parameter int ADDR_WID = DEF_ADDR_WID,
    parameter int DATA_WID = DEF_DATA_WID
) (
    input  logic                clk,
    input  logic                rst_n,
    // cpu port
    input  logic                cpu_rd,
    input  logic                cpu_wr,
    input  logic [ADDR_WID-1:0] cpu_addr,
    input  logic [DATA_WID-1:0] cpu_wdata,
    output logic [DATA_WID-1:0] cpu_rdata,
    output logic                cpu_done,
    // level-2 port
    output logic                lv2_req,
    input  logic                lv2_gnt,
    output logic                lv2_rd,
    output logic                lv2_wr,
    output logic [ADDR_WID-1:0] lv2_addr,
    output logic [DATA_WID-1:0] lv2_wdata,
    input  logic [DATA_WID-1:0] lv2_rdata,
    input  logic                lv2_rdata_valid,
    input  logic                lv2_shared,
    input  logic                lv2_wr_done,
    output logic                bus_rd,
    output logic                bus_rdx,
    output logic                invalidate,
    input  logic                inv_done,
    // snoop port
    input  logic                snoop_inv,
    output logic                inv_ack,
    // lookup results
    input  logic                hit,
    input  logic [NUM_WAYS-1:0] hit_way,
    input  mesi_e               hit_state,
    input  logic [DATA_WID-1:0] hit_data,
    input  logic [NUM_WAYS-1:0] victim_way,
    input  mesi_e               victim_state,
    input  logic [ADDR_WID-$clog2(NUM_SETS)-OFFSET_WID-1:0] victim_tag,
    input  logic [DATA_WID-1:0] victim_data,
    input  logic                snoop_hit_any,
    // array write port
    output logic [NUM_WAYS-1:0] wr_way,
    output logic [$clog2(NUM_SETS)-1:0] wr_index,
    output logic [ADDR_WID-$clog2(NUM_SETS)-OFFSET_WID-1:0] wr_tag,
    output logic [DATA_WID-1:0] wr_data,
    output mesi_e               wr_state,
    output logic                snoop_inv_en,
    output logic                victim_advance
);

    localparam int INDEX_WID = $clog2(NUM_SETS);
    localparam int TAG_WID   = ADDR_WID - INDEX_WID - OFFSET_WID;

    ctrl_state_e state;
    logic        cpu_req;
    logic        fast_hit;
    logic        fast_wr;
    logic        fill_done;

    assign cpu_req   = cpu_rd || cpu_wr;
    // reads hit anywhere, writes only without a bus transaction
    assign fast_hit  = hit && (cpu_rd || hit_state inside {EXCLUSIVE, MODIFIED});
    assign fast_wr   = (state == IDLE) && !snoop_inv && cpu_wr && fast_hit;
    assign fill_done = (state == FILL) && lv2_rdata_valid;

    assign wr_index = cpu_addr[OFFSET_WID +: INDEX_WID];
    assign wr_tag   = cpu_addr[ADDR_WID-1 -: TAG_WID];

    // ====================
    // FSM
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            cpu_done <= 1'b0;
            inv_ack  <= 1'b0;
        end else begin
            cpu_done <= 1'b0;
            inv_ack  <= 1'b0;
            case (state)
                IDLE: begin
                    if (snoop_inv) begin
                        inv_ack <= 1'b1;
                        state   <= DONE;
                    end else if (cpu_req && fast_hit) begin
                        cpu_done <= 1'b1;
                        state    <= DONE;
                    end else if (cpu_req) begin
                        state <= ARB;
                    end
                end
                ARB: begin
                    // a hit here is a write to a SHARED line
                    if (lv2_gnt) begin
                        if (hit) begin
                            state <= INVALIDATE;
                        end else if (victim_state == MODIFIED) begin
                            state <= WRITEBACK;
                        end else begin
                            state <= FILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (lv2_wr_done) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (lv2_rdata_valid) begin
                        cpu_done <= 1'b1;
                        state    <= DONE;
                    end
                end
                INVALIDATE: begin
                    if (inv_done) begin
                        cpu_done <= 1'b1;
                        state    <= DONE;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && cpu_rd && hit) begin
            cpu_rdata <= hit_data;
        end else if (fill_done) begin
            cpu_rdata <= lv2_rdata;
        end
    end

    // ====================
    // level-2 outputs
    // ====================

    assign lv2_req    = state inside {ARB, WRITEBACK, FILL, INVALIDATE};
    assign lv2_wr     = (state == WRITEBACK);
    assign lv2_rd     = (state == FILL);
    assign bus_rd     = (state == FILL) && !cpu_wr;
    assign bus_rdx    = (state == FILL) && cpu_wr;
    assign invalidate = (state == INVALIDATE);
    assign lv2_wdata  = victim_data;

    // writeback goes to the victim's own line address
    assign lv2_addr = (state == WRITEBACK) ?
                      {victim_tag, wr_index, {OFFSET_WID{1'b0}}} :
                      {wr_tag, wr_index, {OFFSET_WID{1'b0}}};

    // ====================
    // array write port
    // ====================

    assign snoop_inv_en   = (state == IDLE) && snoop_inv && snoop_hit_any;
    assign victim_advance = fill_done;

    always_comb begin
        wr_way   = '0;
        wr_data  = cpu_wdata;
        wr_state = MODIFIED;
        if (fast_wr) begin
            wr_way = hit_way;
        end else if (fill_done) begin
            wr_way = victim_way;
            if (!cpu_wr) begin
                wr_data  = lv2_rdata;
                wr_state = lv2_shared ? SHARED : EXCLUSIVE;
            end
        end else if ((state == INVALIDATE) && inv_done) begin
            wr_way = hit_way;
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(lv2_rd && lv2_wr))
        else $error("lv2_rd and lv2_wr high together");

    a_bus_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_rd && bus_rdx))
        else $error("bus_rd and bus_rdx high together");

endmodule

//--- rtl/l1_dcache_top.sv
// Top level of the L1 data cache.
// Connects the access controller, the way arrays and the way selector.

`timescale 1ns/1ps

module l1_dcache_top
    import l1_pkg::*;
#(
    parameter int NUM_WAYS = DEF_NUM_WAYS,
    parameter int NUM_SETS = DEF_NUM_SETS,
    parameter int ADDR_WID = DEF_ADDR_WID,
    parameter int DATA_WID = DEF_DATA_WID
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cpu_rd,
    input  logic                cpu_wr,
    input  logic [ADDR_WID-1:0] cpu_addr,
    input  logic [DATA_WID-1:0] cpu_wdata,
    output logic [DATA_WID-1:0] cpu_rdata,
    output logic                cpu_done,
    output logic                lv2_req,
    input  logic                lv2_gnt,
    output logic                lv2_rd,
    output logic                lv2_wr,
    output logic [ADDR_WID-1:0] lv2_addr,
    output logic [DATA_WID-1:0] lv2_wdata,
    input  logic [DATA_WID-1:0] lv2_rdata,
    input  logic                lv2_rdata_valid,
    input  logic                lv2_shared,
    input  logic                lv2_wr_done,
    output logic                bus_rd,
    output logic                bus_rdx,
    output logic                invalidate,
    input  logic                inv_done,
    input  logic                snoop_inv,
    input  logic [ADDR_WID-1:0] snoop_addr,
    output logic                inv_ack
);

    localparam int INDEX_WID = $clog2(NUM_SETS);
    localparam int TAG_WID   = ADDR_WID - INDEX_WID - OFFSET_WID;

    // array write port
    logic [NUM_WAYS-1:0]  wr_way;
    logic [INDEX_WID-1:0] wr_index;
    logic [TAG_WID-1:0]   wr_tag;
    logic [DATA_WID-1:0]  wr_data;
    mesi_e                wr_state;
    logic                 snoop_inv_en;
    logic                 victim_advance;

    // per-way lookups
    logic [NUM_WAYS-1:0]  way_hit;
    mesi_e                way_state [NUM_WAYS];
    logic [TAG_WID-1:0]   way_tag   [NUM_WAYS];
    logic [DATA_WID-1:0]  way_data  [NUM_WAYS];
    logic [NUM_WAYS-1:0]  way_snoop_hit;

    // selector results
    logic                 hit;
    logic [NUM_WAYS-1:0]  hit_way;
    mesi_e                hit_state;
    logic [DATA_WID-1:0]  hit_data;
    logic [NUM_WAYS-1:0]  victim_way;
    mesi_e                victim_state;
    logic [TAG_WID-1:0]   victim_tag;
    logic [DATA_WID-1:0]  victim_data;
    logic                 snoop_hit_any;

    l1_access_ctrl #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS),
        .ADDR_WID (ADDR_WID),
        .DATA_WID (DATA_WID)
    ) l1_access_ctrl_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_rd          (cpu_rd),
        .cpu_wr          (cpu_wr),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .cpu_rdata       (cpu_rdata),
        .cpu_done        (cpu_done),
        .lv2_req         (lv2_req),
        .lv2_gnt         (lv2_gnt),
        .lv2_rd          (lv2_rd),
        .lv2_wr          (lv2_wr),
        .lv2_addr        (lv2_addr),
        .lv2_wdata       (lv2_wdata),
        .lv2_rdata       (lv2_rdata),
        .lv2_rdata_valid (lv2_rdata_valid),
        .lv2_shared      (lv2_shared),
        .lv2_wr_done     (lv2_wr_done),
        .bus_rd          (bus_rd),
        .bus_rdx         (bus_rdx),
        .invalidate      (invalidate),
        .inv_done        (inv_done),
        .snoop_inv       (snoop_inv),
        .inv_ack         (inv_ack),
        .hit             (hit),
        .hit_way         (hit_way),
        .hit_state       (hit_state),
        .hit_data        (hit_data),
        .victim_way      (victim_way),
        .victim_state    (victim_state),
        .victim_tag      (victim_tag),
        .victim_data     (victim_data),
        .snoop_hit_any   (snoop_hit_any),
        .wr_way          (wr_way),
        .wr_index        (wr_index),
        .wr_tag          (wr_tag),
        .wr_data         (wr_data),
        .wr_state        (wr_state),
        .snoop_inv_en    (snoop_inv_en),
        .victim_advance  (victim_advance)
    );

    // ====================
    // way arrays
    // ====================

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        l1_way_array #(
            .NUM_SETS (NUM_SETS),
            .ADDR_WID (ADDR_WID),
            .DATA_WID (DATA_WID)
        ) l1_way_array_inst (
            .clk          (clk),
            .rst_n        (rst_n),
            .proc_addr    (cpu_addr),
            .snoop_addr   (snoop_addr),
            .wr_en        (wr_way[w]),
            .wr_index     (wr_index),
            .wr_tag       (wr_tag),
            .wr_data      (wr_data),
            .wr_state     (wr_state),
            .snoop_inv_en (snoop_inv_en),
            .proc_hit     (way_hit[w]),
            .proc_state   (way_state[w]),
            .proc_tag     (way_tag[w]),
            .proc_data    (way_data[w]),
            .snoop_hit    (way_snoop_hit[w])
        );
    end

    l1_way_select #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS),
        .ADDR_WID (ADDR_WID),
        .DATA_WID (DATA_WID)
    ) l1_way_select_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .proc_addr      (cpu_addr),
        .way_hit        (way_hit),
        .way_state      (way_state),
        .way_tag        (way_tag),
        .way_data       (way_data),
        .way_snoop_hit  (way_snoop_hit),
        .victim_advance (victim_advance),
        .hit            (hit),
        .hit_way        (hit_way),
        .hit_state      (hit_state),
        .hit_data       (hit_data),
        .victim_way     (victim_way),
        .victim_state   (victim_state),
        .victim_tag     (victim_tag),
        .victim_data    (victim_data),
        .snoop_hit_any  (snoop_hit_any)
    );

endmodule

//--- tb/tb_lv2_model.sv
// Behavioral level-2 memory for the L1 data cache testbench.
// Grants requests, answers fills, writebacks and invalidations after random delays.

`timescale 1ns/1ps

module tb_lv2_model
    import l1_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lv2_req,
    output logic                    lv2_gnt,
    input  logic                    lv2_rd,
    input  logic                    lv2_wr,
    input  logic [DEF_ADDR_WID-1:0] lv2_addr,
    input  logic [DEF_DATA_WID-1:0] lv2_wdata,
    output logic [DEF_DATA_WID-1:0] lv2_rdata,
    output logic                    lv2_rdata_valid,
    output logic                    lv2_shared,
    output logic                    lv2_wr_done,
    input  logic                    invalidate,
    output logic                    inv_done,
    input  logic                    fill_shared
);

    localparam logic [DEF_DATA_WID-1:0] FILL_KEY = 32'hA5A5_0000;

    logic [DEF_DATA_WID-1:0] mem [logic [DEF_ADDR_WID-1:0]];
    logic [31:0] lcg_state = 32'd83770;
    int          gnt_cnt;
    int          op_cnt;
    logic [2:0]  cur_kind;
    logic [2:0]  kind;
    logic        answered;

    // delay of 1 to 4 cycles
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]) + 1;
    endfunction

    // words never written hold their address XOR a key
    function automatic logic [DEF_DATA_WID-1:0] read_word(input logic [DEF_ADDR_WID-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ FILL_KEY;
    endfunction

    initial begin
        lv2_gnt         = 1'b0;
        lv2_rdata       = '0;
        lv2_rdata_valid = 1'b0;
        lv2_shared      = 1'b0;
        lv2_wr_done     = 1'b0;
        inv_done        = 1'b0;
    end

    always @(posedge clk) begin
        kind = {invalidate, lv2_wr, lv2_rd};
        if (!rst_n) begin
            lv2_gnt         <= 1'b0;
            lv2_rdata_valid <= 1'b0;
            lv2_wr_done     <= 1'b0;
            inv_done        <= 1'b0;
            gnt_cnt         = 0;
            op_cnt          = 0;
            cur_kind        = 3'b000;
            answered        = 1'b0;
        end else begin
            lv2_rdata_valid <= 1'b0;
            lv2_wr_done     <= 1'b0;
            inv_done        <= 1'b0;

            // ====================
            // grant
            // ====================
            if (!lv2_req) begin
                lv2_gnt <= 1'b0;
                gnt_cnt = 0;
            end else if (!lv2_gnt) begin
                if (gnt_cnt == 0) begin
                    gnt_cnt = next_delay();
                end else if (gnt_cnt == 1) begin
                    lv2_gnt <= 1'b1;
                end else begin
                    gnt_cnt = gnt_cnt - 1;
                end
            end

            // ====================
            // transfers
            // ====================
            // a new phase starts whenever the command kind changes
            if (kind != cur_kind) begin
                cur_kind = kind;
                op_cnt   = 0;
                answered = 1'b0;
            end else if (kind != 3'b000 && !answered) begin
                if (op_cnt == 0) begin
                    op_cnt = next_delay();
                end else if (op_cnt == 1) begin
                    answered = 1'b1;
                    if (lv2_rd) begin
                        lv2_rdata       <= read_word(lv2_addr);
                        lv2_shared      <= fill_shared;
                        lv2_rdata_valid <= 1'b1;
                    end else if (lv2_wr) begin
                        mem[lv2_addr] = lv2_wdata;
                        lv2_wr_done <= 1'b1;
                    end else begin
                        inv_done <= 1'b1;
                    end
                end else begin
                    op_cnt = op_cnt - 1;
                end
            end
        end
    end

endmodule

//--- tb/tb_l1_dcache.sv
// Testbench top for the L1 data cache.
// Replays tb/l1_trace.txt against the cache and a behavioral level-2 model.

`timescale 1ns/1ps

module tb_l1_dcache
    import l1_pkg::*;
;

    localparam int MAX_OPS = 64;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cpu_rd;
    logic        cpu_wr;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic [31:0] cpu_rdata;
    logic        cpu_done;
    logic        lv2_req;
    logic        lv2_gnt;
    logic        lv2_rd;
    logic        lv2_wr;
    logic [31:0] lv2_addr;
    logic [31:0] lv2_wdata;
    logic [31:0] lv2_rdata;
    logic        lv2_rdata_valid;
    logic        lv2_shared;
    logic        lv2_wr_done;
    logic        bus_rd;
    logic        bus_rdx;
    logic        invalidate;
    logic        inv_done;
    logic        snoop_inv;
    logic [31:0] snoop_addr;
    logic        inv_ack;
    logic        fill_shared;

    // trace contents
    string       op_q      [MAX_OPS];
    logic [31:0] addr_q    [MAX_OPS];
    logic [31:0] wdata_q   [MAX_OPS];
    logic [31:0] rdata_q   [MAX_OPS];
    int          fill_q    [MAX_OPS];
    int          wb_q      [MAX_OPS];
    int          inv_q     [MAX_OPS];
    int          shared_q  [MAX_OPS];
    int          n_ops;

    // last word the trace wrote to each line address
    logic [31:0] written [logic [31:0]];

    int errors;
    int cycle_cnt;
    int cycle_limit;

    always #5 clk = ~clk;

    l1_dcache_top l1_dcache_top_inst (
        .clk (clk), .rst_n (rst_n),
        .cpu_rd (cpu_rd), .cpu_wr (cpu_wr), .cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata), .cpu_done (cpu_done),
        .lv2_req (lv2_req), .lv2_gnt (lv2_gnt), .lv2_rd (lv2_rd), .lv2_wr (lv2_wr),
        .lv2_addr (lv2_addr), .lv2_wdata (lv2_wdata), .lv2_rdata (lv2_rdata),
        .lv2_rdata_valid (lv2_rdata_valid), .lv2_shared (lv2_shared),
        .lv2_wr_done (lv2_wr_done), .bus_rd (bus_rd), .bus_rdx (bus_rdx),
        .invalidate (invalidate), .inv_done (inv_done),
        .snoop_inv (snoop_inv), .snoop_addr (snoop_addr), .inv_ack (inv_ack)
    );

    tb_lv2_model lv2_model_inst (
        .clk (clk), .rst_n (rst_n), .lv2_req (lv2_req), .lv2_gnt (lv2_gnt),
        .lv2_rd (lv2_rd), .lv2_wr (lv2_wr), .lv2_addr (lv2_addr), .lv2_wdata (lv2_wdata),
        .lv2_rdata (lv2_rdata), .lv2_rdata_valid (lv2_rdata_valid),
        .lv2_shared (lv2_shared), .lv2_wr_done (lv2_wr_done),
        .invalidate (invalidate), .inv_done (inv_done), .fill_shared (fill_shared)
    );

    task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    cnt;
        string line;
        fd    = $fopen("tb/l1_trace.txt", "r");
        n_ops = 0;
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file tb/l1_trace.txt");
            return;
        end
        while (!$feof(fd) && n_ops < MAX_OPS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%s %h %h %h %d %d %d %d", op_q[n_ops], addr_q[n_ops],
                          wdata_q[n_ops], rdata_q[n_ops], fill_q[n_ops], wb_q[n_ops],
                          inv_q[n_ops], shared_q[n_ops]);
            if (cnt == 8) begin
                n_ops++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_op(input int i);
        int          n;
        logic        saw_fill;
        logic        saw_wb;
        logic        saw_inv;
        logic        is_wr;
        logic [31:0] line_addr;
        n         = 0;
        saw_fill  = 1'b0;
        saw_wb    = 1'b0;
        saw_inv   = 1'b0;
        is_wr     = (op_q[i] == "W");
        line_addr = addr_q[i] & ~32'h3;
        @(posedge clk);
        fill_shared <= (shared_q[i] != 0);
        if (op_q[i] == "I") begin
            snoop_addr <= addr_q[i];
            snoop_inv  <= 1'b1;
            do begin
                @(negedge clk);
                n++;
            end while (!inv_ack);
            // ack one cycle after the edge that sees the snoop
            check("inv_ack latency", 32'(n), 32'd2);
            @(posedge clk);
            snoop_inv <= 1'b0;
            return;
        end
        cpu_addr  <= addr_q[i];
        cpu_wdata <= wdata_q[i];
        cpu_rd    <= !is_wr;
        cpu_wr    <= is_wr;
        do begin
            @(negedge clk);
            n++;
            if (lv2_rd || lv2_wr || invalidate) begin
                check("lv2_req during transfer", {31'b0, lv2_req}, 32'd1);
            end
            if (lv2_rd) begin
                saw_fill = 1'b1;
                check("fill address", lv2_addr, line_addr);
                check("bus_rd on fill", {31'b0, bus_rd}, {31'b0, !is_wr});
                check("bus_rdx on fill", {31'b0, bus_rdx}, {31'b0, is_wr});
            end
            if (lv2_wr && !saw_wb) begin
                saw_wb = 1'b1;
                // a dirty victim carries the last word written to its line
                if (written.exists(lv2_addr)) begin
                    check("writeback data", lv2_wdata, written[lv2_addr]);
                end else begin
                    errors++;
                    $display("writeback at %0t of line %h that was never written",
                             $time, lv2_addr);
                end
            end
            if (invalidate) begin
                saw_inv = 1'b1;
                check("invalidate address", lv2_addr, line_addr);
            end
        end while (!cpu_done);
        check($sformatf("lv2_req after op %0d", i), {31'b0, lv2_req}, 32'd0);
        if (is_wr) begin
            written[line_addr] = wdata_q[i];
        end
        if (!is_wr) begin
            check($sformatf("read data of %h", addr_q[i]), cpu_rdata, rdata_q[i]);
        end
        check($sformatf("fill flag of op %0d", i), {31'b0, saw_fill}, 32'(fill_q[i]));
        check($sformatf("writeback flag of op %0d", i), {31'b0, saw_wb}, 32'(wb_q[i]));
        check($sformatf("invalidate flag of op %0d", i), {31'b0, saw_inv}, 32'(inv_q[i]));
        if (fill_q[i] == 0 && wb_q[i] == 0 && inv_q[i] == 0) begin
            check($sformatf("hit latency of op %0d", i), 32'(n), 32'd2);
        end
        @(posedge clk);
        cpu_rd <= 1'b0;
        cpu_wr <= 1'b0;
    endtask

    // ====================
    // timeout
    // ====================
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: the run passed its limit of %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst_n       = 1'b0;
        cpu_rd      = 1'b0;
        cpu_wr      = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        snoop_inv   = 1'b0;
        snoop_addr  = '0;
        fill_shared = 1'b0;
        errors      = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        load_trace();
        cycle_limit = 200 * (n_ops + 1);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        @(posedge clk);
        $display("%0d operations run, %0d errors", n_ops, errors);
        if (errors == 0 && n_ops > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- tb/l1_trace.txt
# op addr wdata exp_rdata exp_fill exp_wb exp_inv lv2_shared
# op is R read, W write, I snoop invalidate; hex for addr and data
R 00000100 00000000 A5A50100 1 0 0 0
R 00000100 00000000 A5A50100 0 0 0 0
W 00000100 11110000 00000000 0 0 0 0
R 00000100 00000000 11110000 0 0 0 0
R 00000204 00000000 A5A50204 1 0 0 1
W 00000204 22220000 00000000 0 0 1 0
R 00000204 00000000 22220000 0 0 0 0
W 00000308 33330000 00000000 1 0 0 0
R 00000308 00000000 33330000 0 0 0 0
R 00000140 00000000 A5A50140 1 0 0 0
R 00000180 00000000 A5A50180 1 0 0 0
R 000001C0 00000000 A5A501C0 1 0 0 0
R 00000200 00000000 A5A50200 1 1 0 0
R 00000100 00000000 11110000 1 0 0 0
W 00000180 44440000 00000000 0 0 0 0
R 00000240 00000000 A5A50240 1 1 0 0
R 00000180 00000000 44440000 1 0 0 0
I 00000100 00000000 00000000 0 0 0 0
R 00000100 00000000 11110000 1 0 0 0
I 00000500 00000000 00000000 0 0 0 0
W 00000580 55550000 00000000 1 0 0 0
R 00000580 00000000 55550000 0 0 0 0
W 00000100 66660000 00000000 0 0 0 0
R 00000200 00000000 A5A50200 1 1 0 0
R 00000100 00000000 66660000 1 0 0 0
W 00000C0C 77770000 00000000 1 0 0 1
R 00000C0C 00000000 77770000 0 0 0 0

//--- vlog.f
rtl/l1_pkg.sv
rtl/l1_way_array.sv
rtl/l1_way_select.sv
rtl/l1_access_ctrl.sv
rtl/l1_dcache_top.sv
tb/tb_lv2_model.sv
tb/tb_l1_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --Wno-fatal \
    --top-module tb_l1_dcache \
    -f vlog.f \
    -o sim_l1_dcache

./obj_dir/sim_l1_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
